// File: hdl/rvPkg.sv
package rvPkg;

    localparam int XLEN = 32;                 // data and address width

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,                // add sub and or xor slt
        opImm    = 7'b0010011,                // addi andi ori xori slti
        opLoad   = 7'b0000011,                // lw
        opStore  = 7'b0100011,                // sw
        opBranch = 7'b1100011,                // beq bne
        opJal    = 7'b1101111,                // jal
        opLui    = 7'b0110111                 // lui
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,                      // also used for branch compare
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluXor   = 3'd4,
        aluSlt   = 3'd5,                      // signed less than
        aluPassB = 3'd6                       // b straight through, for lui
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'd0,                          // alu immediates and loads
        immS = 3'd1,                          // stores
        immB = 3'd2,                          // branches, bit 0 zero
        immJ = 3'd3,                          // jal, bit 0 zero
        immU = 3'd4                           // lui, low 12 bits zero
    } immSrcT;

    // funct3 codes, alu group
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 codes, branch group
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    // funct3 for word sized lw / sw
    localparam logic [2:0] f3Word   = 3'b010;

endpackage

// File: hdl/ctrlIf.sv
`timescale 1ns/1ps

// decoded control levels, valid for the whole cycle
interface ctrlIf import rvPkg::*; ();

    logic   regWrite;                         // write rd this cycle
    aluOpT  aluCtrl;                          // alu operation
    logic   aluSrc;                           // b operand is the immediate
    immSrcT immSrc;                           // immediate format
    logic   pcSrc;                            // branch taken, pc + imm
    logic   memWrite;                         // store to data memory
    logic   resultSrc;                        // writeback from memRdata
    logic   jalSel;                           // writeback pc + 4, jump

    modport decoder (
        output regWrite, aluCtrl, aluSrc, immSrc,
        output pcSrc, memWrite, resultSrc, jalSel
    );

    modport datapath (
        input regWrite, aluCtrl, aluSrc, immSrc,
        input pcSrc, memWrite, resultSrc, jalSel
    );

endinterface

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import rvPkg::*; (
    input  logic [6:0] op,                    // instr[6:0]
    input  logic [2:0] funct3,                // instr[14:12]
    input  logic       funct7b5,              // instr[30], sub select
    input  logic       zero,                  // from alu, branch compare
    ctrlIf.decoder     ctrl
);

    aluOpT f3Op;                              // alu op picked by funct3
    logic  f3Valid;                           // funct3 is in the subset
    logic  branchHit;                         // branch condition met

    // shared by R-type and I-type
    always_comb
    begin
        f3Op    = aluAdd;
        f3Valid = 1'b1;
        case (funct3)
            f3AddSub: f3Op = aluAdd;
            f3Slt:    f3Op = aluSlt;
            f3Xor:    f3Op = aluXor;
            f3Or:     f3Op = aluOr;
            f3And:    f3Op = aluAnd;
            default:  f3Valid = 1'b0;         // shifts, sltu left out
        endcase
    end

    // beq wants equal, bne wants different
    always_comb
    begin
        case (funct3)
            f3Beq:   branchHit = zero;
            f3Bne:   branchHit = ~zero;
            default: branchHit = 1'b0;        // other branches never taken
        endcase
    end

    always_comb
    begin
        // everything inactive unless the opcode says otherwise
        ctrl.regWrite  = 1'b0;
        ctrl.aluCtrl   = aluAdd;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSrc    = immI;
        ctrl.pcSrc     = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.resultSrc = 1'b0;
        ctrl.jalSel    = 1'b0;

        case (op)
            opReg:
            begin
                ctrl.regWrite = f3Valid;
                ctrl.aluCtrl  = f3Op;
                if (funct3 == f3AddSub && funct7b5)
                    ctrl.aluCtrl = aluSub;    // sub only on R-type
            end
            opImm:
            begin
                ctrl.regWrite = f3Valid;
                ctrl.aluCtrl  = f3Op;         // instr[30] is imm here
                ctrl.aluSrc   = 1'b1;
            end
            opLoad:
            begin
                ctrl.regWrite  = (funct3 == f3Word);
                ctrl.aluSrc    = 1'b1;        // rs1 + offset
                ctrl.resultSrc = 1'b1;
            end
            opStore:
            begin
                ctrl.immSrc   = immS;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = (funct3 == f3Word);
            end
            opBranch:
            begin
                ctrl.immSrc  = immB;
                ctrl.aluCtrl = aluSub;        // zero flag means rs1 == rs2
                ctrl.pcSrc   = branchHit;
            end
            opJal:
            begin
                ctrl.regWrite = 1'b1;         // link
                ctrl.immSrc   = immJ;
                ctrl.jalSel   = 1'b1;
            end
            opLui:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.immSrc   = immU;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluCtrl  = aluPassB;
            end
            default: ;                        // unsupported, plain no-op
        endcase
    end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] wdata,
    ctrlIf.datapath         ctrl,             // regWrite only
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [1:31];             // x0 has no storage

    // write on rising edge, x0 writes dropped
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (ctrl.regWrite && rd != 5'd0)
        begin
            regs[rd] <= wdata;
        end
    end

    // async reads, x0 reads as zero
    always_comb
    begin
        rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
        rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  logic [XLEN-1:0] a,                // rs1 value
    input  logic [XLEN-1:0] b,                // rs2 value or immediate
    ctrlIf.datapath         ctrl,             // aluCtrl
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [XLEN-1:0] diff;                    // shared by sub and slt
    logic            lessThan;                // signed a < b

    assign diff     = a - b;
    assign lessThan = $signed(a) < $signed(b);

    always_comb
    begin
        case (ctrl.aluCtrl)
            aluAdd:
                result = a + b;
            aluSub:
                result = diff;
            aluAnd:
                result = a & b;
            aluOr:
                result = a | b;
            aluXor:
                result = a ^ b;
            aluSlt:
                result = {{(XLEN-1){1'b0}}, lessThan};
            aluPassB:
                result = b;                   // lui upper immediate
            default:
                result = '0;
        endcase
    end

    // branch compare, beq / bne both read this
    assign zero = (result == '0);

endmodule

// File: hdl/immExtend.sv
`timescale 1ns/1ps

module immExtend import rvPkg::*; (
    input  logic [31:0]     instr,
    ctrlIf.datapath         ctrl,             // immSrc
    output logic [XLEN-1:0] imm
);

    logic sign;                               // instr[31] in every format

    assign sign = instr[31];

    always_comb
    begin
        case (ctrl.immSrc)
            immI:
                imm = {{20{sign}}, instr[31:20]};
            immS:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            immB:
                // halfword offset, bit 0 forced low
                imm = {{20{sign}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            immJ:
                imm = {{12{sign}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            immU:
                imm = {instr[31:12], 12'b0};  // upper 20 bits, low zeroed
            default:
                imm = '0;
        endcase
    end

endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/1ps

module pcUnit import rvPkg::*; #(
    parameter logic [XLEN-1:0] resetVector = '0  // first fetch address
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic [XLEN-1:0] imm,              // branch or jal offset
    ctrlIf.datapath         ctrl,             // pcSrc, jalSel
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pcPlus4           // also the jal link value
);

    logic [XLEN-1:0] pcTarget;                // pc relative target
    logic [XLEN-1:0] pcNext;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;

    // taken branch or jal, else sequential
    assign pcNext = (ctrl.pcSrc || ctrl.jalSel) ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            pc <= resetVector;
        else
            pc <= pcNext;
    end

endmodule

// File: hdl/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter logic [XLEN-1:0] resetVector = '0
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic [31:0]     instr,            // fetched word for pc
    output logic [XLEN-1:0] pc,               // fetch address
    output logic [XLEN-1:0] memAddr,          // alu result
    output logic [XLEN-1:0] memWdata,         // rs2 value
    output logic            memWrite,
    input  logic [XLEN-1:0] memRdata          // same cycle read data
);

    // instruction fields
    logic [6:0]      opcode;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    logic            funct7b5;

    // datapath nets
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic            zero;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] wbData;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign funct7b5 = instr[30];

    ctrlIf ctrlBus ();                        // decoder to datapath

    controlUnit decoderInst (
        .op       (opcode),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .zero     (zero),
        .ctrl     (ctrlBus.decoder)
    );

    regFile regFileInst (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wbData),
        .ctrl   (ctrlBus.datapath),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    immExtend immInst (
        .instr (instr),
        .ctrl  (ctrlBus.datapath),
        .imm   (imm)
    );

    assign aluB = ctrlBus.aluSrc ? imm : rdata2;   // immediate or rs2

    alu aluInst (
        .a      (rdata1),
        .b      (aluB),
        .ctrl   (ctrlBus.datapath),
        .result (aluResult),
        .zero   (zero)
    );

    pcUnit #(
        .resetVector (resetVector)
    ) pcInst (
        .clk     (clk),
        .rstN    (rstN),
        .imm     (imm),
        .ctrl    (ctrlBus.datapath),
        .pc      (pc),
        .pcPlus4 (pcPlus4)
    );

    // writeback priority: link, then load, then alu
    always_comb
    begin
        if (ctrlBus.jalSel)
            wbData = pcPlus4;
        else if (ctrlBus.resultSrc)
            wbData = memRdata;
        else
            wbData = aluResult;
    end

    // data memory side
    assign memAddr  = aluResult;              // rs1 + offset for lw / sw
    assign memWdata = rdata2;
    assign memWrite = ctrlBus.memWrite;

endmodule

// File: bench/rvCoreChecker.sv
`timescale 1ns/1ps

module rvCoreChecker #(
    parameter logic [31:0] resetVector = '0
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWdata,
    input  logic        memWrite,
    output int          errorCount,
    output int          checkCount
);

    logic [31:0] refRegs [0:31];              // architectural registers
    logic [31:0] refMem [0:63];               // mirror of the data memory
    logic [31:0] refPc;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] immI;
    logic [31:0] ldAddr;
    logic [31:0] stAddr;
    logic [31:0] wbVal;
    logic [31:0] nextPc;
    logic        wbEn;
    logic        expWrite;
    int          resetEdges;                  // rising edges seen in reset

    initial
    begin
        errorCount = 0;
        checkCount = 0;
        resetEdges = 0;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("Mismatch %s: got %h, expected %h, at %0t", name, got, expected, $time);
        end
    endtask

    // add sub slt xor or and, nothing else in the subset
    function automatic logic aluF3Ok(input logic [2:0] code);
        case (code)
            3'b000, 3'b010, 3'b100, 3'b110, 3'b111: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] refAlu(input logic [2:0] code, input logic subOp,
                                           input logic [31:0] a, input logic [31:0] b);
        case (code)
            3'b000:  return subOp ? a - b : a + b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};   // signed compare
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // sampled on the rising edge, instr and outputs settled since the falling edge
    always @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int r = 0; r < 32; r++)
                refRegs[r] = '0;
            for (int w = 0; w < 64; w++)
                refMem[w] = 32'hda7a0000 + 32'(4 * w);   // same fill as the bench memory
            refPc = resetVector;
            if (resetEdges > 0)
                checkValue("pc", pc, resetVector);      // loaded by the first reset edge at the latest
            resetEdges++;
            checkValue("memWrite", {31'b0, memWrite}, 32'd0);
        end
        else
        begin
            rs1v     = refRegs[instr[19:15]];
            rs2v     = refRegs[instr[24:20]];
            immI     = {{20{instr[31]}}, instr[31:20]};
            ldAddr   = rs1v + immI;
            stAddr   = rs1v + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            nextPc   = refPc + 32'd4;                     // default, also for no-ops
            wbEn     = 1'b0;
            wbVal    = '0;
            expWrite = 1'b0;
            case (instr[6:0])
                7'b0110011:
                begin
                    wbEn  = aluF3Ok(instr[14:12]);
                    wbVal = refAlu(instr[14:12], instr[30], rs1v, rs2v);
                end
                7'b0010011:
                begin
                    wbEn  = aluF3Ok(instr[14:12]);
                    wbVal = refAlu(instr[14:12], 1'b0, rs1v, immI);
                end
                7'b0000011:
                begin
                    wbEn  = (instr[14:12] == 3'b010);      // lw only
                    wbVal = refMem[ldAddr[7:2]];
                end
                7'b0100011:
                    expWrite = (instr[14:12] == 3'b010);   // sw only
                7'b1100011:
                    if ((instr[14:12] == 3'b000 && rs1v == rs2v) ||
                        (instr[14:12] == 3'b001 && rs1v != rs2v))
                        nextPc = refPc + {{20{instr[31]}}, instr[7], instr[30:25],
                                          instr[11:8], 1'b0};
                7'b1101111:
                begin
                    wbEn   = 1'b1;
                    wbVal  = refPc + 32'd4;                // link
                    nextPc = refPc + {{12{instr[31]}}, instr[19:12], instr[20],
                                      instr[30:21], 1'b0};
                end
                7'b0110111:
                begin
                    wbEn  = 1'b1;
                    wbVal = {instr[31:12], 12'b0};
                end
                default: ;                                 // unsupported, pc + 4 only
            endcase
            checkValue("pc", pc, refPc);
            checkValue("memWrite", {31'b0, memWrite}, {31'b0, expWrite});
            if (expWrite)
            begin
                checkValue("memAddr", memAddr, stAddr);
                checkValue("memWdata", memWdata, rs2v);
                refMem[stAddr[7:2]] = rs2v;
            end
            if (wbEn && instr[11:7] != 5'd0)
                refRegs[instr[11:7]] = wbVal;              // x0 stays zero
            refPc = nextPc;
        end
    end

endmodule

// File: bench/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;

    localparam int          maxCycles   = 2000;                   // run limit
    localparam logic [31:0] resetVector = 32'h0;
    localparam logic [31:0] lastAddr    = resetVector + 32'd252;  // closing self jump

    logic        clk = 1'b0;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic        memWrite;
    logic [31:0] progMem [0:63];              // instruction memory image
    logic [31:0] dataMem [0:63];              // data memory, word index addr[7:2]
    int          seed;
    int          cycles;
    int          errorCount;
    int          checkCount;
    logic        timedOut;

    always #5 clk = ~clk;                     // 10 ns period

    rvCore #(.resetVector(resetVector)) rvCore_inst (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc),
        .memAddr(memAddr), .memWdata(memWdata), .memWrite(memWrite),
        .memRdata(memRdata)
    );

    rvCoreChecker #(.resetVector(resetVector)) checkInst (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc),
        .memAddr(memAddr), .memWdata(memWdata), .memWrite(memWrite),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    assign memRdata = dataMem[memAddr[7:2]];  // same cycle read port

    always @(posedge clk)
    begin
        if (rstN && memWrite)
            dataMem[memAddr[7:2]] <= memWdata;
    end

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // random supported instructions, forward targets only so the run ends
    task automatic buildProgram();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [12:0] bOff;
        logic [20:0] jOff;
        for (int i = 0; i < 63; i++)
        begin
            kind = randBelow(20);
            rd   = 5'(randBelow(8));          // x0..x7 keeps data flowing
            rs1  = 5'(randBelow(8));
            rs2  = 5'(randBelow(8));
            case (randBelow(5))
                0:       f3 = 3'b000;
                1:       f3 = 3'b010;
                2:       f3 = 3'b100;
                3:       f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            off  = 12'(4 * randBelow(64));    // word offset from x0
            bOff = 13'(4 * (1 + randBelow(63 - i)));
            jOff = 21'(bOff);
            if (kind == 0)
                progMem[i] = {25'($random(seed)), 7'b0010111};   // auipc, not supported
            else if (kind <= 5)
                progMem[i] = {1'b0, (f3 == 3'b000) & 1'(randBelow(2)), 5'b0,
                              rs2, rs1, f3, rd, 7'b0110011};
            else if (kind <= 9)
                progMem[i] = {12'($random(seed)), rs1, f3, rd, 7'b0010011};
            else if (kind <= 11)
                progMem[i] = {off, 5'd0, 3'b010, rd, 7'b0000011};
            else if (kind <= 14)
                progMem[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
            else if (kind <= 16)
                progMem[i] = {bOff[12], bOff[10:5], rs2, rs1, 2'b00, 1'(randBelow(2)),
                              bOff[4:1], bOff[11], 7'b1100011};
            else if (kind == 17)
                progMem[i] = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, 7'b1101111};
            else
                progMem[i] = {20'($random(seed)), rd, 7'b0110111};
        end
        progMem[63] = 32'h0000006f;           // jal x0, 0
    endtask

    initial
    begin
        seed     = 32'h4c43;
        rstN     = 1'b0;
        instr    = '0;                        // no-op while in reset
        timedOut = 1'b0;
        for (int w = 0; w < 64; w++)
            dataMem[w] = 32'hda7a0000 + 32'(4 * w);
        buildProgram();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN   = 1'b1;
        instr  = progMem[pc[7:2]];
        cycles = 0;
        while (pc != lastAddr && !timedOut)   // wait for the program to park
        begin
            @(negedge clk);
            instr = progMem[pc[7:2]];
            cycles++;
            if (cycles >= maxCycles)
                timedOut = 1'b1;
        end
        if (timedOut)
            $display("Timeout: pc did not reach the closing jal in %0d cycles", maxCycles);
        repeat (8)                            // pc must hold on the self jump
        begin
            @(negedge clk);
            instr = progMem[pc[7:2]];
        end
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 checkCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut && checkCount > 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: rvCore.f
hdl/rvPkg.sv
hdl/ctrlIf.sv
hdl/controlUnit.sv
hdl/regFile.sv
hdl/alu.sv
hdl/immExtend.sv
hdl/pcUnit.sv
hdl/rvCore.sv
bench/rvCoreChecker.sv
bench/rvCoreTb.sv

// File: Bender.yml
package:
  name: rvcore

sources:
  - hdl/rvPkg.sv
  - hdl/ctrlIf.sv
  - hdl/controlUnit.sv
  - hdl/regFile.sv
  - hdl/alu.sv
  - hdl/immExtend.sv
  - hdl/pcUnit.sv
  - hdl/rvCore.sv
  - target: test
    files:
      - bench/rvCoreChecker.sv
      - bench/rvCoreTb.sv
